/* verilog/lsu_pkg.sv */
package lsu_pkg;

    // Integer data path width, also used for addresses
    localparam int xlen = 64;

    // Architectural register index width
    localparam int reg_addr_w = 5;

    // Width of the signed immediate offset of a load or store
    localparam int offset_w = 12;

    // The data memory holds this many doublewords
    localparam int ram_depth = 512;
    localparam int ram_idx_w = $clog2(ram_depth);

    // Byte position inside one doubleword
    localparam int byte_off_w = 3;

    // Access width code as carried on the issue side
    typedef enum logic [1:0] {
        mw_byte   = 2'd0,
        mw_half   = 2'd1,
        mw_word   = 2'd2,
        mw_double = 2'd3
    } mem_width_e;

    // Response FIFO payload holds read data, byte offset, unsigned flag, width, dst and pc
    localparam int fifo_w = xlen + byte_off_w + 1 + $bits(mem_width_e) + reg_addr_w + xlen;

endpackage

/* verilog/fifo_1d_fwft.sv */
module fifo_1d_fwft #(
    parameter int width = 64
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [width-1:0] a_data,
    input  logic             a_valid,
    output logic             a_ready,
    output logic [width-1:0] b_data,
    output logic             b_valid,
    input  logic             b_ready
);

    // Single storage slot and its occupancy flag
    logic [width-1:0] entry;
    logic             full;

    // Room exists when the slot is empty or is being read out on this edge
    assign a_ready = !full || b_ready;

    // The held entry is visible on the output side as soon as it is written
    assign b_valid = full;
    assign b_data  = entry;

    // Occupancy tracking
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            full <= 1'b0;
        end else begin
            if (a_valid && a_ready) begin
                // A write wins over a drain in the same cycle
                full <= 1'b1;
            end else if (b_ready) begin
                full <= 1'b0;
            end
        end
    end

    // Payload capture
    always_ff @(posedge clk) begin
        if (a_valid && a_ready) begin
            entry <= a_data;
        end
    end

endmodule

/* verilog/load_align.sv */
module load_align (
    input  logic [lsu_pkg::xlen-1:0]       rdata,
    input  logic [lsu_pkg::byte_off_w-1:0] byte_offset,
    input  lsu_pkg::mem_width_e            mem_width,
    input  logic                           mem_unsigned,
    output logic [lsu_pkg::xlen-1:0]       result
);

    import lsu_pkg::*;

    // Lanes of the returned doubleword picked by the low address bits
    logic [7:0]  byte_lane;
    logic [15:0] half_lane;
    logic [31:0] word_lane;

    // Bit position of each lane inside the doubleword
    logic [5:0] byte_pos;
    logic [5:0] half_pos;
    logic [5:0] word_pos;

    // A byte lane starts at offset times 8, a halfword at bits 2..1 times 16
    assign byte_pos = {byte_offset, 3'b000};
    assign half_pos = {byte_offset[2:1], 4'b0000};
    assign word_pos = {byte_offset[2], 5'b00000};

    assign byte_lane = rdata[byte_pos +: 8];
    assign half_lane = rdata[half_pos +: 16];
    assign word_lane = rdata[word_pos +: 32];

    // Extend the selected lane to the full register width
    always_comb begin
        case (mem_width)
            mw_byte: begin
                // Zero fill for unsigned loads, copy of the lane's top bit otherwise
                result = {{(xlen - 8){byte_lane[7] & !mem_unsigned}}, byte_lane};
            end
            mw_half: begin
                result = {{(xlen - 16){half_lane[15] & !mem_unsigned}}, half_lane};
            end
            mw_word: begin
                result = {{(xlen - 32){word_lane[31] & !mem_unsigned}}, word_lane};
            end
            default: begin
                // A doubleword fills the register, nothing to extend
                result = rdata;
            end
        endcase
    end

endmodule

/* verilog/lsp.sv */
module lsp (
    input  logic                           clk,
    input  logic                           rst_n,
    output logic [lsu_pkg::xlen-1:0]       dm_req_addr,
    output logic [lsu_pkg::xlen-1:0]       dm_req_wdata,
    output logic                           dm_req_wen,
    output logic                           dm_req_valid,
    input  logic [lsu_pkg::xlen-1:0]       dm_resp_rdata,
    input  logic                           dm_resp_valid,
    input  logic [lsu_pkg::xlen-1:0]       ix_lsp_pc,
    input  logic [lsu_pkg::reg_addr_w-1:0] ix_lsp_dst,
    input  logic                           ix_lsp_wb_en,
    input  logic [lsu_pkg::xlen-1:0]       ix_lsp_base,
    input  logic [lsu_pkg::offset_w-1:0]   ix_lsp_offset,
    input  logic [lsu_pkg::xlen-1:0]       ix_lsp_source,
    input  logic                           ix_lsp_mem_unsigned,
    input  lsu_pkg::mem_width_e            ix_lsp_mem_width,
    input  logic                           ix_lsp_valid,
    output logic                           ix_lsp_ready,
    output logic [lsu_pkg::xlen-1:0]       lsp_ix_result,
    output logic [lsu_pkg::reg_addr_w-1:0] lsp_ix_dst,
    output logic [lsu_pkg::xlen-1:0]       lsp_ix_pc,
    output logic                           lsp_ix_valid,
    input  logic                           lsp_ix_ready
);

    import lsu_pkg::*;

    // Effective address and issue handshake
    logic [xlen-1:0] agu_addr;
    logic            accept;
    logic            outstanding;

    // Load metadata kept from issue until the memory answers
    logic                  ag_load;
    logic [byte_off_w-1:0] ag_byte_offset;
    logic                  ag_unsigned;
    mem_width_e            ag_width;
    logic [reg_addr_w-1:0] ag_dst;
    logic [xlen-1:0]       ag_pc;

    // Response buffer
    logic              fifo_push;
    logic              fifo_a_ready;
    logic [fifo_w-1:0] fifo_in;
    logic [fifo_w-1:0] fifo_out;

    // Buffered response fields on the writeback side
    logic [xlen-1:0]       wb_rdata;
    logic [byte_off_w-1:0] wb_byte_offset;
    logic                  wb_unsigned;
    logic [1:0]            wb_width;

    // Base plus the sign extended immediate
    assign agu_addr = ix_lsp_base
                    + {{(xlen - offset_w){ix_lsp_offset[offset_w-1]}}, ix_lsp_offset};

    // Only a load response goes to writeback
    assign fifo_push = dm_resp_valid && ag_load;

    // Issue waits while a request has no answer yet, and while the buffer is full and held.
    // It also waits in the cycle a load result enters the buffer, since the slot would
    // otherwise be taken when the next answer arrives under writeback stall
    assign ix_lsp_ready = !(outstanding && !dm_resp_valid) && !fifo_push && fifo_a_ready;
    assign accept       = ix_lsp_valid && ix_lsp_ready;

    // Request strobe and the single outstanding flag
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dm_req_valid <= 1'b0;
            outstanding  <= 1'b0;
        end else begin
            // One strobe per accepted access
            dm_req_valid <= accept;
            if (accept) begin
                outstanding <= 1'b1;
            end else if (dm_resp_valid) begin
                outstanding <= 1'b0;
            end
        end
    end

    // Address generation registers, loaded on every accepted access
    always_ff @(posedge clk) begin
        if (accept) begin
            dm_req_addr    <= agu_addr;
            dm_req_wdata   <= ix_lsp_source;
            // A store is any access without writeback
            dm_req_wen     <= !ix_lsp_wb_en;
            ag_load        <= ix_lsp_wb_en;
            ag_byte_offset <= agu_addr[byte_off_w-1:0];
            ag_unsigned    <= ix_lsp_mem_unsigned;
            ag_width       <= ix_lsp_mem_width;
            ag_dst         <= ix_lsp_dst;
            ag_pc          <= ix_lsp_pc;
        end
    end

    // Read data and its metadata travel together, so memory latency does not matter
    assign fifo_in = {dm_resp_rdata, ag_byte_offset, ag_unsigned, ag_width, ag_dst, ag_pc};

    fifo_1d_fwft #(
        .width(fifo_w)
    ) u_resp_fifo (
        .clk    (clk),
        .rst_n  (rst_n),
        .a_data (fifo_in),
        .a_valid(fifo_push),
        .a_ready(fifo_a_ready),
        .b_data (fifo_out),
        .b_valid(lsp_ix_valid),
        .b_ready(lsp_ix_ready)
    );

    // Split the buffer head back into fields, in the same order as packed
    assign {wb_rdata, wb_byte_offset, wb_unsigned, wb_width, lsp_ix_dst, lsp_ix_pc} = fifo_out;

    // Lane select and extension of the buffered doubleword
    load_align u_load_align (
        .rdata       (wb_rdata),
        .byte_offset (wb_byte_offset),
        .mem_width   (mem_width_e'(wb_width)),
        .mem_unsigned(wb_unsigned),
        .result      (lsp_ix_result)
    );

endmodule

/* verilog/data_ram.sv */
module data_ram (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [lsu_pkg::xlen-1:0] req_addr,
    input  logic [lsu_pkg::xlen-1:0] req_wdata,
    input  logic                     req_wen,
    input  logic                     req_valid,
    output logic [lsu_pkg::xlen-1:0] resp_rdata,
    output logic                     resp_valid
);

    import lsu_pkg::*;

    // Doubleword storage
    logic [xlen-1:0] mem [ram_depth];

    // Doubleword index, the low three address bits pick a byte and are dropped here
    logic [ram_idx_w-1:0] idx;

    assign idx = req_addr[ram_idx_w+byte_off_w-1:byte_off_w];

    // Every request is answered one cycle later, writes included
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= req_valid;
        end
    end

    // Array access
    always_ff @(posedge clk) begin
        if (req_valid) begin
            if (req_wen) begin
                // No byte enables, the full doubleword is replaced
                mem[idx] <= req_wdata;
            end else begin
                resp_rdata <= mem[idx];
            end
        end
    end

    // Write responses leave resp_rdata unchanged

endmodule

/* verilog/lsu_top.sv */
module lsu_top (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [lsu_pkg::xlen-1:0]       ix_lsp_pc,
    input  logic [lsu_pkg::reg_addr_w-1:0] ix_lsp_dst,
    input  logic                           ix_lsp_wb_en,
    input  logic [lsu_pkg::xlen-1:0]       ix_lsp_base,
    input  logic [lsu_pkg::offset_w-1:0]   ix_lsp_offset,
    input  logic [lsu_pkg::xlen-1:0]       ix_lsp_source,
    input  logic                           ix_lsp_mem_unsigned,
    input  lsu_pkg::mem_width_e            ix_lsp_mem_width,
    input  logic                           ix_lsp_valid,
    output logic                           ix_lsp_ready,
    output logic [lsu_pkg::xlen-1:0]       lsp_ix_result,
    output logic [lsu_pkg::reg_addr_w-1:0] lsp_ix_dst,
    output logic [lsu_pkg::xlen-1:0]       lsp_ix_pc,
    output logic                           lsp_ix_valid,
    input  logic                           lsp_ix_ready
);

    import lsu_pkg::*;

    // Request and response path between the pipeline and the data memory
    logic [xlen-1:0] dm_req_addr;
    logic [xlen-1:0] dm_req_wdata;
    logic            dm_req_wen;
    logic            dm_req_valid;
    logic [xlen-1:0] dm_resp_rdata;
    logic            dm_resp_valid;

    lsp u_lsp (
        .clk                (clk),
        .rst_n              (rst_n),
        .dm_req_addr        (dm_req_addr),
        .dm_req_wdata       (dm_req_wdata),
        .dm_req_wen         (dm_req_wen),
        .dm_req_valid       (dm_req_valid),
        .dm_resp_rdata      (dm_resp_rdata),
        .dm_resp_valid      (dm_resp_valid),
        .ix_lsp_pc          (ix_lsp_pc),
        .ix_lsp_dst         (ix_lsp_dst),
        .ix_lsp_wb_en       (ix_lsp_wb_en),
        .ix_lsp_base        (ix_lsp_base),
        .ix_lsp_offset      (ix_lsp_offset),
        .ix_lsp_source      (ix_lsp_source),
        .ix_lsp_mem_unsigned(ix_lsp_mem_unsigned),
        .ix_lsp_mem_width   (ix_lsp_mem_width),
        .ix_lsp_valid       (ix_lsp_valid),
        .ix_lsp_ready       (ix_lsp_ready),
        .lsp_ix_result      (lsp_ix_result),
        .lsp_ix_dst         (lsp_ix_dst),
        .lsp_ix_pc          (lsp_ix_pc),
        .lsp_ix_valid       (lsp_ix_valid),
        .lsp_ix_ready       (lsp_ix_ready)
    );

    // Single cycle memory, so each request sees its answer on the following cycle
    data_ram u_data_ram (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_addr  (dm_req_addr),
        .req_wdata (dm_req_wdata),
        .req_wen   (dm_req_wen),
        .req_valid (dm_req_valid),
        .resp_rdata(dm_resp_rdata),
        .resp_valid(dm_resp_valid)
    );

endmodule

/* dv/tb_lsu_top.sv */
module tb_lsu_top;

    import lsu_pkg::*;

    localparam int max_entries      = 96;
    localparam int clk_period       = 10;
    localparam int reset_cycles     = 5;
    localparam int cycles_per_entry = 20;
    localparam int drain_cycles     = 100;

    // One row of the stimulus table
    typedef struct packed {
        logic                  is_load;
        logic [xlen-1:0]       base;
        logic [offset_w-1:0]   offset;
        logic [xlen-1:0]       data;
        mem_width_e            width;
        logic                  uns;
        logic [reg_addr_w-1:0] dst;
        logic [xlen-1:0]       pc;
        logic [3:0]            stall;
    } access_t;

    // A load result waiting to show up on the writeback side
    typedef struct packed {
        int                    test;
        logic [xlen-1:0]       result;
        logic [reg_addr_w-1:0] dst;
        logic [xlen-1:0]       pc;
        logic [3:0]            stall;
    } expect_t;

    logic                  clk;
    logic                  rst_n;
    logic [xlen-1:0]       ix_lsp_pc;
    logic [reg_addr_w-1:0] ix_lsp_dst;
    logic                  ix_lsp_wb_en;
    logic [xlen-1:0]       ix_lsp_base;
    logic [offset_w-1:0]   ix_lsp_offset;
    logic [xlen-1:0]       ix_lsp_source;
    logic                  ix_lsp_mem_unsigned;
    mem_width_e            ix_lsp_mem_width;
    logic                  ix_lsp_valid;
    logic                  ix_lsp_ready;
    logic [xlen-1:0]       lsp_ix_result;
    logic [reg_addr_w-1:0] lsp_ix_dst;
    logic [xlen-1:0]       lsp_ix_pc;
    logic                  lsp_ix_valid;
    logic                  lsp_ix_ready;

    access_t         tbl [max_entries];
    int              n_tests;
    logic            table_ready;
    logic [xlen-1:0] ref_mem [ram_depth];
    expect_t         exp_q [$];
    int              error_cnt;
    int              pass_cnt;
    int              fail_cnt;

    lsu_top u_lsu_top (
        .clk                (clk),
        .rst_n              (rst_n),
        .ix_lsp_pc          (ix_lsp_pc),
        .ix_lsp_dst         (ix_lsp_dst),
        .ix_lsp_wb_en       (ix_lsp_wb_en),
        .ix_lsp_base        (ix_lsp_base),
        .ix_lsp_offset      (ix_lsp_offset),
        .ix_lsp_source      (ix_lsp_source),
        .ix_lsp_mem_unsigned(ix_lsp_mem_unsigned),
        .ix_lsp_mem_width   (ix_lsp_mem_width),
        .ix_lsp_valid       (ix_lsp_valid),
        .ix_lsp_ready       (ix_lsp_ready),
        .lsp_ix_result      (lsp_ix_result),
        .lsp_ix_dst         (lsp_ix_dst),
        .lsp_ix_pc          (lsp_ix_pc),
        .lsp_ix_valid       (lsp_ix_valid),
        .lsp_ix_ready       (lsp_ix_ready)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(clk_period / 2);
            clk = ~clk;
        end
    end

    // Base plus the sign extended 12-bit immediate
    function automatic logic [xlen-1:0] effective_addr(input logic [xlen-1:0] base,
                                                       input logic [offset_w-1:0] offset);
        return base + xlen'($signed(offset));
    endfunction

    // Doubleword slot of the memory taken from address bits 11 to 3
    function automatic logic [ram_idx_w-1:0] ref_index(input logic [xlen-1:0] addr);
        return addr[11:3];
    endfunction

    // Expected load value from the doubleword, the offset and the width code
    function automatic logic [xlen-1:0] predict_load(input logic [xlen-1:0] dw,
                                                     input logic [2:0] off,
                                                     input mem_width_e width,
                                                     input logic uns);
        int              bytes;
        int              start;
        logic [xlen-1:0] mask;
        logic [xlen-1:0] lane;
        bytes = 1 << int'(width);
        // Lanes sit at multiples of their own size
        start = int'(off) & ~(bytes - 1);
        lane  = dw >> (start * 8);
        if (bytes == 8) begin
            return lane;
        end
        mask = (64'd1 << (bytes * 8)) - 64'd1;
        lane = lane & mask;
        // Signed loads copy the lane's top bit into all higher bits
        if (!uns && lane[bytes*8-1]) begin
            lane = lane | ~mask;
        end
        return lane;
    endfunction

    task automatic check_result(input logic [xlen-1:0] got, input logic [xlen-1:0] exp);
        if (got !== exp) begin
            $display("error at %0t: lsp_ix_result is %h, expected %h", $time, got, exp);
            error_cnt++;
        end
    endtask

    task automatic check_dst(input logic [reg_addr_w-1:0] got,
                             input logic [reg_addr_w-1:0] exp);
        if (got !== exp) begin
            $display("error at %0t: lsp_ix_dst is %0d, expected %0d", $time, got, exp);
            error_cnt++;
        end
    endtask

    task automatic check_pc(input logic [xlen-1:0] got, input logic [xlen-1:0] exp);
        if (got !== exp) begin
            $display("error at %0t: lsp_ix_pc is %h, expected %h", $time, got, exp);
            error_cnt++;
        end
    endtask

    // Appends one row whose dst and pc follow from the row number
    task automatic add_access(input logic is_load, input logic [xlen-1:0] base,
                              input logic [offset_w-1:0] offset, input logic [xlen-1:0] data,
                              input mem_width_e width, input logic uns, input logic [3:0] stall);
        tbl[n_tests].is_load = is_load;
        tbl[n_tests].base    = base;
        tbl[n_tests].offset  = offset;
        tbl[n_tests].data    = data;
        tbl[n_tests].width   = width;
        tbl[n_tests].uns     = uns;
        tbl[n_tests].dst     = reg_addr_w'(n_tests % 31 + 1);
        tbl[n_tests].pc      = 64'h8000_0000 + 64'(n_tests) * 64'd4;
        tbl[n_tests].stall   = stall;
        n_tests++;
    endtask

    task automatic build_table();
        int         slot;
        int         boff;
        mem_width_e w;
        // Every lane of this pattern has its top bit set
        add_access(1'b0, 64'h100, 12'h000, 64'hF1E2_D3C4_B5A6_9788, mw_double, 1'b0, 4'd0);
        add_access(1'b1, 64'h100, 12'h000, '0, mw_double, 1'b0, 4'd0);
        for (int off = 0; off < 8; off++) begin
            add_access(1'b1, 64'h100, 12'(off), '0, mw_byte, 1'b0, 4'd0);
            add_access(1'b1, 64'h100, 12'(off), '0, mw_byte, 1'b1, 4'd0);
        end
        for (int off = 0; off < 8; off += 2) begin
            add_access(1'b1, 64'h100, 12'(off), '0, mw_half, 1'b0, 4'd0);
            add_access(1'b1, 64'h100, 12'(off), '0, mw_half, 1'b1, 4'd0);
        end
        for (int off = 0; off < 8; off += 4) begin
            add_access(1'b1, 64'h100, 12'(off), '0, mw_word, 1'b0, 4'd0);
            add_access(1'b1, 64'h100, 12'(off), '0, mw_word, 1'b1, 4'd0);
        end
        // Negative offsets and offsets that carry into the next doubleword
        add_access(1'b0, 64'h208, 12'hFF8, 64'h8000_7FFF_0123_FEDC, mw_double, 1'b0, 4'd0);
        add_access(1'b1, 64'h1F0, 12'h010, '0, mw_double, 1'b0, 4'd0);
        add_access(1'b1, 64'h1FC, 12'h008, '0, mw_word, 1'b0, 4'd0);
        add_access(1'b1, 64'h203, 12'hFFE, '0, mw_byte, 1'b0, 4'd0);
        // A byte wide store still writes all eight bytes
        add_access(1'b0, 64'h300, 12'h000, 64'h1111_2222_3333_4444, mw_double, 1'b0, 4'd0);
        add_access(1'b0, 64'h300, 12'h000, 64'hA5A5_5A5A_C3C3_3C3C, mw_byte, 1'b0, 4'd0);
        add_access(1'b1, 64'h300, 12'h000, '0, mw_double, 1'b0, 4'd0);
        // Back to back loads under writeback stall
        add_access(1'b1, 64'h100, 12'h000, '0, mw_double, 1'b0, 4'd6);
        add_access(1'b1, 64'h100, 12'h002, '0, mw_half, 1'b0, 4'd0);
        add_access(1'b1, 64'h100, 12'h004, '0, mw_word, 1'b1, 4'd4);
        // Random data in eight doublewords followed by random loads reaching them from above
        for (int k = 0; k < 8; k++) begin
            w = mem_width_e'(2'($urandom_range(0, 3)));
            add_access(1'b0, 64'h400, 12'(k * 8), {$urandom(), $urandom()}, w, 1'b0, 4'd0);
        end
        for (int k = 0; k < 24; k++) begin
            slot = $urandom_range(0, 7);
            w    = mem_width_e'(2'($urandom_range(0, 3)));
            boff = $urandom_range(0, 7);
            boff = boff & ~((1 << int'(w)) - 1);
            add_access(1'b1, 64'h440 + 64'(slot) * 64'd8, 12'(boff - 64), '0, w,
                       1'($urandom_range(0, 1)), 4'($urandom_range(0, 3)));
        end
    endtask

    // Starts on a falling edge and returns on a falling edge once the access is done with
    // A load is done at the edge after acceptance and a store once its writeback slot passed
    task automatic apply_access(input int i);
        access_t         a;
        logic [xlen-1:0] addr;
        expect_t         e;
        a    = tbl[i];
        addr = effective_addr(a.base, a.offset);
        ix_lsp_valid        = 1'b1;
        ix_lsp_wb_en        = a.is_load;
        ix_lsp_base         = a.base;
        ix_lsp_offset       = a.offset;
        ix_lsp_source       = a.data;
        ix_lsp_mem_width    = a.width;
        ix_lsp_mem_unsigned = a.uns;
        ix_lsp_dst          = a.dst;
        ix_lsp_pc           = a.pc;
        #1;
        while (ix_lsp_ready !== 1'b1) begin
            @(negedge clk);
            #1;
        end
        @(posedge clk);
        if (a.is_load) begin
            e.test   = i;
            e.result = predict_load(ref_mem[ref_index(addr)], addr[2:0], a.width, a.uns);
            e.dst    = a.dst;
            e.pc     = a.pc;
            e.stall  = a.stall;
            exp_q.push_back(e);
            @(negedge clk);
        end else begin
            ref_mem[ref_index(addr)] = a.data;
            @(negedge clk);
            ix_lsp_valid = 1'b0;
            // A load issued here would show its result two edges after acceptance
            repeat (2) @(negedge clk);
            if (lsp_ix_valid === 1'b1 && lsp_ix_pc === a.pc) begin
                $display("store at %h was followed by a writeback carrying its pc %h",
                         addr, a.pc);
                error_cnt++;
                $display("test %0d store to %h: FAILED", i, addr);
                fail_cnt++;
            end else begin
                $display("test %0d store to %h: ok", i, addr);
                pass_cnt++;
            end
        end
    endtask

    // Writeback side model that holds ready low for the row's stall count and checks each cycle
    task automatic monitor_results();
        int      wait_cnt;
        int      errors_at_start;
        expect_t e;
        wait_cnt        = 0;
        errors_at_start = 0;
        forever begin
            @(negedge clk);
            if (rst_n !== 1'b1 || lsp_ix_valid !== 1'b1) begin
                lsp_ix_ready = 1'b1;
            end else if (exp_q.size() == 0) begin
                $display("unexpected writeback at %0t with pc %h while no load is pending",
                         $time, lsp_ix_pc);
                error_cnt++;
                lsp_ix_ready = 1'b1;
            end else begin
                e = exp_q[0];
                if (wait_cnt == 0) begin
                    errors_at_start = error_cnt;
                end
                // A stalled result must stay the same until it is taken
                check_result(lsp_ix_result, e.result);
                check_dst(lsp_ix_dst, e.dst);
                check_pc(lsp_ix_pc, e.pc);
                if (wait_cnt < int'(e.stall)) begin
                    lsp_ix_ready = 1'b0;
                    wait_cnt++;
                end else begin
                    lsp_ix_ready = 1'b1;
                    exp_q.delete(0);
                    wait_cnt = 0;
                    if (error_cnt == errors_at_start) begin
                        $display("test %0d load pc %h: ok", e.test, e.pc);
                        pass_cnt++;
                    end else begin
                        $display("test %0d load pc %h: FAILED", e.test, e.pc);
                        fail_cnt++;
                    end
                end
            end
        end
    endtask

    initial begin
        int drain;
        table_ready         = 1'b0;
        rst_n               = 1'b0;
        ix_lsp_valid        = 1'b0;
        ix_lsp_wb_en        = 1'b0;
        ix_lsp_base         = '0;
        ix_lsp_offset       = '0;
        ix_lsp_source       = '0;
        ix_lsp_mem_width    = mw_byte;
        ix_lsp_mem_unsigned = 1'b0;
        ix_lsp_dst          = '0;
        ix_lsp_pc           = '0;
        lsp_ix_ready        = 1'b1;
        error_cnt           = 0;
        pass_cnt            = 0;
        fail_cnt            = 0;
        n_tests             = 0;
        void'($urandom(38455));
        build_table();
        table_ready = 1'b1;
        fork
            monitor_results();
        join_none
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        // Idle state of the pipeline straight out of reset
        if (lsp_ix_valid !== 1'b0 || ix_lsp_ready !== 1'b1) begin
            $display("idle state after reset is wrong, lsp_ix_valid %b and ix_lsp_ready %b",
                     lsp_ix_valid, ix_lsp_ready);
            error_cnt++;
        end else begin
            $display("test reset idle state: ok");
        end
        rst_n = 1'b1;
        for (int i = 0; i < n_tests; i++) begin
            apply_access(i);
        end
        ix_lsp_valid = 1'b0;
        drain = 0;
        while (exp_q.size() != 0 && drain < drain_cycles) begin
            @(negedge clk);
            drain++;
        end
        if (exp_q.size() != 0) begin
            $display("result missing for test %0d, the load never reached writeback",
                     exp_q[0].test);
            fail_cnt += exp_q.size();
            error_cnt++;
        end
        // A few idle cycles to catch a stray writeback
        repeat (10) @(negedge clk);
        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 n_tests, pass_cnt, fail_cnt, error_cnt);
        if (error_cnt == 0 && fail_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // Run time limit scales with the number of table rows
    initial begin
        wait (table_ready === 1'b1);
        repeat (n_tests * cycles_per_entry + reset_cycles) @(posedge clk);
        $display("timeout, the run did not finish within %0d cycles",
                 n_tests * cycles_per_entry + reset_cycles);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

/* lsu.f */
verilog/lsu_pkg.sv
verilog/fifo_1d_fwft.sv
verilog/load_align.sv
verilog/lsp.sv
verilog/data_ram.sv
verilog/lsu_top.sv
dv/tb_lsu_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

build_dir=obj_dir
log_file=sim.log

rm -rf "$build_dir" "$log_file"

verilator --binary --timing \
    --top-module tb_lsu_top \
    -f lsu.f \
    --Mdir "$build_dir" \
    -o sim_lsu

"./$build_dir/sim_lsu" | tee "$log_file"

if grep -q "PASS: all tests" "$log_file"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
